/* Bender.yml */
package:
  name: sd_cmd_controller

sources:
  - design/sd_cmd_pkg.sv
  - design/sd_cmd_decode.sv
  - design/sd_cmd_serial.sv
  - design/sd_cmd_result.sv
  - design/sd_cmd_controller.sv
  - target: test
    files:
      - dv/sd_cmd_assertions.sv
      - dv/sd_cmd_tb.sv

/* sd_cmd_controller.f */
design/sd_cmd_pkg.sv
design/sd_cmd_decode.sv
design/sd_cmd_serial.sv
design/sd_cmd_result.sv
design/sd_cmd_controller.sv
dv/sd_cmd_assertions.sv
dv/sd_cmd_tb.sv

/* dv/sd_cmd_tb.sv */
`timescale 1ns/10ps

module sd_cmd_tb
    import sd_cmd_pkg::*;
();

    localparam int N_CMDS     = 60;
    localparam int WAIT_LIMIT = 1000;
    localparam int FAULT_CRC  = 3;
    localparam int FAULT_IDX  = 4;
    localparam int FAULT_END  = 5;

    logic        sd_clk;
    logic        arst_n;
    logic        req;
    cmd_req_t    req_data;
    logic        ack;
    resp_data_t  resp;
    cmd_status_t status;
    cmd_status_t int_enable;
    logic        irq;
    logic        sd_cmd_in;
    logic        sd_cmd_out;
    logic        sd_cmd_oe;
    logic [31:0] rng_state;

    sd_cmd_controller DUT (
        .sd_clk_i     (sd_clk),
        .arst_n_i     (arst_n),
        .req_i        (req),
        .req_data_i   (req_data),
        .ack_o        (ack),
        .resp_o       (resp),
        .status_o     (status),
        .int_enable_i (int_enable),
        .irq_o        (irq),
        .sd_cmd_i     (sd_cmd_in),
        .sd_cmd_o     (sd_cmd_out),
        .sd_cmd_oe_o  (sd_cmd_oe)
    );

    bind sd_cmd_controller sd_cmd_assertions sva (.*);

    initial begin
        sd_clk = 1'b0;
        forever #4 sd_clk = ~sd_clk;
    end

    always @(negedge sd_clk) begin
        if (DUT.sva.fail_count != 0) begin
            fail_now("a bound assertion on the controller ports failed");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // remainder of msg * x^7 by long division with x^7 + x^3 + 1
    function automatic logic [6:0] crc7_div(input logic [135:0] msg, input int len);
        logic [7:0] rem;
        rem = '0;
        for (int i = 0; i < len + 7; i++) begin
            rem = {rem[6:0], (i < len) ? msg[135 - i] : 1'b0};
            if (rem[7]) begin
                rem ^= 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_resp(input resp_data_t got, input resp_data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: resp_o got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_status(input cmd_status_t got, input cmd_status_t exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: status_o got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // card captures the command and answers after the Ncr gap
    task automatic card_side(input logic [47:0] exp_frame, input logic [135:0] bits,
                             input int len, input int delay);
        logic [47:0] frame;
        int          n_high;
        int          waited;
        frame  = '0;
        n_high = 0;
        waited = 0;
        @(negedge sd_clk);
        while (!sd_cmd_oe) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("no command frame appeared on the CMD line");
            end
            @(negedge sd_clk);
        end
        while (sd_cmd_oe && n_high < 64) begin
            frame = {frame[46:0], sd_cmd_out};
            n_high++;
            @(negedge sd_clk);
        end
        compare_value("sd_cmd_oe_o cycles", n_high, 48);
        compare_value("sd_cmd_o frame", frame, exp_frame);
        if (len > 0) begin
            // first driven bit lands two cycles after the end bit
            @(posedge sd_clk);
            #1;
            repeat (delay) begin
                @(posedge sd_clk);
                #1;
            end
            for (int i = 0; i < len; i++) begin
                sd_cmd_in = bits[135 - i];
                @(posedge sd_clk);
                #1;
            end
            sd_cmd_in = 1'b1;
        end
    endtask

    task automatic host_side(input resp_data_t exp_resp, input cmd_status_t exp_status,
                             input int hold);
        int          waited;
        logic [31:0] r;
        waited = 0;
        req    = 1'b1;
        @(negedge sd_clk);
        while (!ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("ack_o did not rise after req_i was raised");
            end
            @(negedge sd_clk);
        end
        compare_resp(resp, exp_resp);
        compare_status(status, exp_status);
        compare_value("irq_o", irq, |(exp_status & int_enable));
        // host stalls with req high while irq follows new enables
        for (int i = 0; i < hold; i++) begin
            @(posedge sd_clk);
            #1;
            r          = next_rand();
            int_enable = r[4:0];
            @(negedge sd_clk);
            compare_value("ack_o", ack, 1'b1);
            compare_value("irq_o", irq, |(exp_status & int_enable));
        end
        @(posedge sd_clk);
        #1;
        req    = 1'b0;
        waited = 0;
        @(negedge sd_clk);
        while (ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("ack_o did not fall after req_i was lowered");
            end
            @(negedge sd_clk);
        end
        compare_status(status, exp_status);
    endtask

    task automatic run_command();
        cmd_req_t     rq;
        logic [31:0]  r;
        logic [127:0] content;
        logic [135:0] bits;
        logic [39:0]  body;
        logic [5:0]   echo;
        resp_data_t   exp_resp;
        cmd_status_t  exp_status;
        int           delay;
        int           fault;
        int           len;
        r            = next_rand();
        rq.cmd_index = r[5:0];
        rq.resp_kind = resp_kind_e'(r[7:6]);
        delay        = r[15:8] % 81;
        fault        = r[23:16] % 6;
        rq.argument  = next_rand();
        content      = {next_rand(), next_rand(), next_rand(), next_rand()};
        r            = next_rand();
        int_enable   = r[4:0];
        body         = {1'b0, 1'b1, rq.cmd_index, rq.argument};
        echo         = (fault == FAULT_IDX) ? (rq.cmd_index ^ (r[10:5] | 6'd1)) : rq.cmd_index;
        bits         = '0;
        len          = 0;
        exp_resp     = '0;
        if (rq.resp_kind == RESP_LONG) begin
            len            = LONG_RESP_BITS;
            bits[135:8]    = {2'b00, 6'h3f, content[119:0]};
            bits[7:1]      = crc7_div({content[119:0], 16'h0}, 120);
            exp_resp       = content[119:0];
        end else if (rq.resp_kind != RESP_NONE) begin
            len            = SHORT_RESP_BITS;
            bits[135:96]   = {2'b00, echo, content[31:0]};
            bits[95:89]    = crc7_div(bits, 40);
            exp_resp[31:0] = content[31:0];
        end
        if (len > 0) begin
            bits[136 - len] = (fault != FAULT_END);
            if (fault == FAULT_CRC) begin
                bits[137 - len + (r[13:11] % 7)] ^= 1'b1;
            end
        end

        exp_status = '0;
        if (rq.resp_kind == RESP_NONE) begin
            exp_status.complete = 1'b1;
        end else if (delay + 2 > NCR_MAX) begin
            exp_status.timeout = 1'b1;
            exp_resp           = '0;
        end else begin
            exp_status.complete  = 1'b1;
            exp_status.crc_err   = (fault == FAULT_CRC) && (rq.resp_kind != RESP_SHORT_NOCRC);
            exp_status.index_err = (fault == FAULT_IDX) && (rq.resp_kind == RESP_SHORT);
            exp_status.end_err   = (fault == FAULT_END);
        end

        req_data = rq;
        fork
            host_side(exp_resp, exp_status, r[18:16]);
            card_side({body, crc7_div({body, 96'h0}, 40), 1'b1}, bits, len, delay);
        join
        @(posedge sd_clk);
        #1;
    endtask

    initial begin
        rng_state  = 32'hd118_9512;
        arst_n     = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        int_enable = '0;
        sd_cmd_in  = 1'b1;
        repeat (5) @(posedge sd_clk);
        #1;
        arst_n = 1'b1;
        @(negedge sd_clk);
        compare_value("ack_o", ack, 1'b0);
        compare_value("irq_o", irq, 1'b0);
        compare_value("sd_cmd_oe_o", sd_cmd_oe, 1'b0);
        compare_value("sd_cmd_o", sd_cmd_out, 1'b1);
        compare_status(status, '0);
        @(posedge sd_clk);
        #1;
        repeat (N_CMDS) run_command();
        if (DUT.sva.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_now("a bound assertion on the controller ports failed");
        end
    end

endmodule

/* dv/sd_cmd_assertions.sv */
`timescale 1ns/10ps

module sd_cmd_assertions
    import sd_cmd_pkg::*;
(
    input logic        sd_clk_i,
    input logic        arst_n_i,
    input logic        req_i,
    input logic        ack_o,
    input logic        sd_cmd_oe_o,
    input cmd_status_t status_o,
    input cmd_status_t int_enable_i,
    input logic        irq_o
);

    int fail_count = 0;

    // ack only drops once req is gone
    ack_after_req: assert property (
        @(posedge sd_clk_i) disable iff (!arst_n_i)
        $fell(ack_o) |-> !$past(req_i)
    ) else begin
        $error("ack_o fell while req_i was still high");
        fail_count++;
    end

    no_send_during_ack: assert property (
        @(posedge sd_clk_i) disable iff (!arst_n_i)
        $rose(sd_cmd_oe_o) |-> (!ack_o && !$past(ack_o))
    ) else begin
        $error("sd_cmd_oe_o rose while ack_o was high");
        fail_count++;
    end

    irq_is_masked_status: assert property (
        @(posedge sd_clk_i) disable iff (!arst_n_i)
        irq_o == |(status_o & int_enable_i)
    ) else begin
        $error("irq_o does not match status_o masked by int_enable_i");
        fail_count++;
    end

endmodule

/* design/sd_cmd_controller.sv */
`timescale 1ns/10ps

module sd_cmd_controller
    import sd_cmd_pkg::*;
(
    input  logic        sd_clk_i,
    input  logic        arst_n_i,
    input  logic        req_i,
    input  cmd_req_t    req_data_i,
    output logic        ack_o,
    output resp_data_t  resp_o,
    output cmd_status_t status_o,
    input  cmd_status_t int_enable_i,
    output logic        irq_o,
    input  logic        sd_cmd_i,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o
);

    logic       frame_valid;
    cmd_frame_t frame;
    logic       raw_valid;
    resp_raw_t  raw;
    logic       accept_ready;

    sd_cmd_decode sd_cmd_decode0 (
        .sd_clk_i       (sd_clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .req_data_i     (req_data_i),
        .accept_ready_i (accept_ready),
        .frame_valid_o  (frame_valid),
        .frame_o        (frame)
    );

    sd_cmd_serial sd_cmd_serial0 (
        .sd_clk_i      (sd_clk_i),
        .arst_n_i      (arst_n_i),
        .frame_valid_i (frame_valid),
        .frame_i       (frame),
        .sd_cmd_i      (sd_cmd_i),
        .sd_cmd_o      (sd_cmd_o),
        .sd_cmd_oe_o   (sd_cmd_oe_o),
        .raw_valid_o   (raw_valid),
        .raw_o         (raw)
    );

    // index field of the frame body
    sd_cmd_result sd_cmd_result0 (
        .sd_clk_i       (sd_clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .frame_valid_i  (frame_valid),
        .sent_index_i   (frame.body[37:32]),
        .sent_kind_i    (frame.resp_kind),
        .raw_valid_i    (raw_valid),
        .raw_i          (raw),
        .int_enable_i   (int_enable_i),
        .accept_ready_o (accept_ready),
        .ack_o          (ack_o),
        .resp_o         (resp_o),
        .status_o       (status_o),
        .irq_o          (irq_o)
    );

endmodule

/* design/sd_cmd_result.sv */
`timescale 1ns/10ps

module sd_cmd_result
    import sd_cmd_pkg::*;
(
    input  logic        sd_clk_i,
    input  logic        arst_n_i,
    input  logic        req_i,
    input  logic        frame_valid_i,
    input  logic [5:0]  sent_index_i,
    input  resp_kind_e  sent_kind_i,
    input  logic        raw_valid_i,
    input  resp_raw_t   raw_i,
    input  cmd_status_t int_enable_i,
    output logic        accept_ready_o,
    output logic        ack_o,
    output resp_data_t  resp_o,
    output cmd_status_t status_o,
    output logic        irq_o
);

    logic        in_flight_q;
    cmd_status_t status_d;
    resp_data_t  resp_d;

    always_comb begin
        status_d          = '0;
        status_d.complete = !raw_i.timed_out;
        status_d.timeout  = raw_i.timed_out;
        if (!raw_i.timed_out) begin
            status_d.crc_err   = ((sent_kind_i == RESP_SHORT) || (sent_kind_i == RESP_LONG)) &&
                                 !raw_i.crc_ok;
            status_d.end_err   = (sent_kind_i != RESP_NONE) && !raw_i.end_ok;
            // echoed index sits right after start and transmission bits
            status_d.index_err = (sent_kind_i == RESP_SHORT) &&
                                 (raw_i.bits[133:128] != sent_index_i);
        end
    end

    always_comb begin
        resp_d = '0;
        if (!raw_i.timed_out) begin
            case (sent_kind_i)
                RESP_LONG:                    resp_d = raw_i.bits[127:8];
                RESP_SHORT, RESP_SHORT_NOCRC: resp_d[31:0] = raw_i.bits[127:96];
                default:                      resp_d = '0;
            endcase
        end
    end

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_flight_q <= 1'b0;
            ack_o       <= 1'b0;
            status_o    <= '0;
        end else begin
            if (frame_valid_i) begin
                in_flight_q <= 1'b1;
                status_o    <= '0;
            end
            if (raw_valid_i) begin
                ack_o    <= 1'b1;
                status_o <= status_d;
            end else if (ack_o && !req_i) begin
                // host dropped req, close the handshake
                ack_o       <= 1'b0;
                in_flight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (raw_valid_i) begin
            resp_o <= resp_d;
        end
    end

    assign accept_ready_o = !in_flight_q && !ack_o;
    assign irq_o          = |(status_o & int_enable_i);

endmodule

/* design/sd_cmd_serial.sv */
`timescale 1ns/10ps

module sd_cmd_serial
    import sd_cmd_pkg::*;
(
    input  logic       sd_clk_i,
    input  logic       arst_n_i,
    input  logic       frame_valid_i,
    input  cmd_frame_t frame_i,
    input  logic       sd_cmd_i,
    output logic       sd_cmd_o,
    output logic       sd_cmd_oe_o,
    output logic       raw_valid_o,
    output resp_raw_t  raw_o
);

    serial_state_e state_q;
    resp_kind_e    kind_q;
    logic [7:0]    bit_cnt_q;
    logic          timed_out_q;
    logic [6:0]    crc_q;
    logic [135:0]  shift_q;
    logic          tx_bit;
    logic [7:0]    rx_last;
    logic          rx_in_crc;

    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'd0);
    endfunction

    // body bits, then crc MSB first, then end bit
    always_comb begin
        if (bit_cnt_q < 8'(CMD_FRAME_BITS - 8)) begin
            tx_bit = shift_q[135];
        end else if (bit_cnt_q < 8'(CMD_FRAME_BITS - 1)) begin
            tx_bit = crc_q[6];
        end else begin
            tx_bit = 1'b1;
        end
    end

    assign rx_last = (kind_q == RESP_LONG) ? 8'(LONG_RESP_BITS - 1) : 8'(SHORT_RESP_BITS - 1);

    // long response skips the 8 header bits
    always_comb begin
        if (kind_q == RESP_LONG) begin
            rx_in_crc = (bit_cnt_q >= 8'd8) && (bit_cnt_q < 8'(LONG_RESP_BITS - 8));
        end else begin
            rx_in_crc = bit_cnt_q < 8'(SHORT_RESP_BITS - 8);
        end
    end

    assign sd_cmd_oe_o = (state_q == SEND);
    assign sd_cmd_o    = (state_q == SEND) ? tx_bit : 1'b1;
    assign raw_valid_o = (state_q == DONE);

    always_comb begin
        if (kind_q == RESP_LONG) begin
            raw_o.bits = shift_q;
        end else begin
            raw_o.bits = {shift_q[SHORT_RESP_BITS-1:0],
                          {(LONG_RESP_BITS - SHORT_RESP_BITS){1'b0}}};
        end
        raw_o.crc_ok    = (crc_q == shift_q[7:1]);
        raw_o.end_ok    = shift_q[0];
        raw_o.timed_out = timed_out_q;
    end

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            kind_q      <= RESP_NONE;
            bit_cnt_q   <= '0;
            timed_out_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (frame_valid_i) begin
                        state_q     <= SEND;
                        kind_q      <= frame_i.resp_kind;
                        bit_cnt_q   <= '0;
                        timed_out_q <= 1'b0;
                    end
                end
                SEND: begin
                    bit_cnt_q <= bit_cnt_q + 8'd1;
                    if (bit_cnt_q == 8'(CMD_FRAME_BITS - 1)) begin
                        bit_cnt_q <= '0;
                        if (kind_q == RESP_NONE) begin
                            state_q <= DONE;
                        end else begin
                            state_q <= WAIT_START;
                        end
                    end
                end
                WAIT_START: begin
                    // counter doubles as the Ncr wait count here
                    bit_cnt_q <= bit_cnt_q + 8'd1;
                    if (!sd_cmd_i) begin
                        bit_cnt_q <= 8'd1;
                        state_q   <= RECEIVE;
                    end else if (bit_cnt_q == 8'(NCR_MAX - 1)) begin
                        timed_out_q <= 1'b1;
                        state_q     <= DONE;
                    end
                end
                RECEIVE: begin
                    bit_cnt_q <= bit_cnt_q + 8'd1;
                    if (bit_cnt_q == rx_last) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // one shift register and one crc register for both directions
    always_ff @(posedge sd_clk_i) begin
        case (state_q)
            IDLE: begin
                if (frame_valid_i) begin
                    shift_q <= {frame_i.body, {(LONG_RESP_BITS - CMD_FRAME_BITS + 8){1'b0}}};
                    crc_q   <= '0;
                end
            end
            SEND: begin
                if (bit_cnt_q < 8'(CMD_FRAME_BITS - 8)) begin
                    crc_q   <= crc7_step(crc_q, shift_q[135]);
                    shift_q <= shift_q << 1;
                end else begin
                    crc_q <= {crc_q[5:0], 1'b0};
                end
            end
            WAIT_START: begin
                // start bit of 0 leaves the crc at zero
                crc_q <= '0;
                if (!sd_cmd_i) begin
                    shift_q <= {shift_q[134:0], 1'b0};
                end
            end
            RECEIVE: begin
                shift_q <= {shift_q[134:0], sd_cmd_i};
                if (rx_in_crc) begin
                    crc_q <= crc7_step(crc_q, sd_cmd_i);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* design/sd_cmd_decode.sv */
`timescale 1ns/10ps

module sd_cmd_decode
    import sd_cmd_pkg::*;
(
    input  logic       sd_clk_i,
    input  logic       arst_n_i,
    input  logic       req_i,
    input  cmd_req_t   req_data_i,
    input  logic       accept_ready_i,
    output logic       frame_valid_o,
    output cmd_frame_t frame_o
);

    logic req_q;
    logic req_rise;
    logic accept;

    assign req_rise = req_i && !req_q;

    // a new request only counts while nothing is in flight
    assign accept = req_rise && accept_ready_i;

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q         <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            req_q         <= req_i;
            frame_valid_o <= accept;
        end
    end

    // start bit 0, transmission bit 1
    always_ff @(posedge sd_clk_i) begin
        if (accept) begin
            frame_o.body      <= {1'b0, 1'b1, req_data_i.cmd_index, req_data_i.argument};
            frame_o.resp_kind <= req_data_i.resp_kind;
        end
    end

endmodule

/* design/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // command and response lengths on the CMD line
    localparam int CMD_FRAME_BITS  = 48;
    localparam int SHORT_RESP_BITS = 48;
    localparam int LONG_RESP_BITS  = 136;

    // response start bit must show up within this many cycles
    localparam int NCR_MAX = 64;

    // x^7 + x^3 + 1
    localparam logic [6:0] CRC7_POLY = 7'h09;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_SHORT,
        RESP_SHORT_NOCRC,
        RESP_LONG
    } resp_kind_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_START,
        RECEIVE,
        DONE
    } serial_state_e;

    typedef struct packed {
        logic [5:0]  cmd_index;
        logic [31:0] argument;
        resp_kind_e  resp_kind;
    } cmd_req_t;

    // body is start, transmission, index, argument
    typedef struct packed {
        logic [39:0] body;
        resp_kind_e  resp_kind;
    } cmd_frame_t;

    // bits are left aligned, first received bit at 135
    typedef struct packed {
        logic [135:0] bits;
        logic         crc_ok;
        logic         end_ok;
        logic         timed_out;
    } resp_raw_t;

    typedef logic [119:0] resp_data_t;

    typedef struct packed {
        logic complete;
        logic timeout;
        logic crc_err;
        logic index_err;
        logic end_err;
    } cmd_status_t;

endpackage
